// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_rv_decoder
FILELIST  := rv_decoder.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: rv_decoder.f
verilog/decoder_pkg.sv
verilog/instr_capture.sv
verilog/alu_op_decode.sv
verilog/mem_op_decode.sv
verilog/flow_op_decode.sv
verilog/ctl_issue.sv
verilog/rv_decoder.sv
tests/tb_rv_decoder.sv

// File: tests/tb_rv_decoder.sv
`timescale 1ns/1ps

module tb_rv_decoder
    import decoder_pkg::*;
();
    localparam int TIMEOUT = 50;

    logic   clk;
    logic   rst;
    logic   in_req;
    logic   in_ack;
    instr_t instr;
    logic   out_req;
    logic   out_ack;
    ctl_t   ctl;

    int          cycle_count;
    int          req_cycle;
    logic [15:0] lfsr;

    rv_decoder uut (
        .clk     (clk),
        .rst     (rst),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .instr   (instr),
        .out_req (out_req),
        .out_ack (out_ack),
        .ctl     (ctl)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_timeout(string what);
        $display("timed out waiting for %s at time %0t", what, $time);
        abort_run();
    endtask

    task automatic check_ctl(string name, ctl_t exp, ctl_t act);
        if (act !== exp) begin
            $display("FAIL time=%0t signal=%s expected=%h (%s) actual=%h (%s)",
                     $time, name, exp, exp.op.name(), act, act.op.name());
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAIL time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("FAIL time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    // 16-bit fibonacci lfsr with taps 16, 14, 13 and 11
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // fields the decoder ignores stay random and top_w picks a funct7 or funct6 field
    function automatic instr_t encode(logic [6:0] opc, logic has_f3, logic [2:0] f3,
                                      int top_w, logic [6:0] top);
        instr_t w;
        w = rand_bits(32);
        w[6:0] = opc;
        if (has_f3) begin
            w[14:12] = f3;
        end
        if (top_w == 7) begin
            w[31:25] = top;
        end else if (top_w == 6) begin
            w[31:26] = top[5:0];
        end
        return w;
    endfunction

    function automatic ctl_t expected_ctl(op_e op);
        ctl_t c;
        c    = '0;
        c.op = op;
        case (op)
            ADDI, ADD, AUIPC, JAL, JALR: c.alu_func = ALU_ADD;
            SUB:                         c.alu_func = ALU_SUB;
            ANDI, AND:                   c.alu_func = ALU_AND;
            ORI, OR:                     c.alu_func = ALU_OR;
            XORI, XOR:                   c.alu_func = ALU_XOR;
            SLTI, SLT:                   c.alu_func = ALU_SLT_S;
            SLTIU, SLTU:                 c.alu_func = ALU_SLT_U;
            SLLI, SLL:                   c.alu_func = ALU_SLL;
            SRLI, SRL:                   c.alu_func = ALU_SRL;
            SRAI, SRA:                   c.alu_func = ALU_SRA;
            LUI, SB, SH, SW, SD:         c.alu_func = ALU_DIRECT;
            default:                     c.alu_func = ALU_NOP;
        endcase
        c.mem_read  = op inside {LB, LH, LW, LD, LBU, LHU, LWU};
        c.mem_write = op inside {SB, SH, SW, SD};
        c.reg_write = (op != OP_UNKNOWN) && !c.mem_write
                      && !(op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU});
        return c;
    endfunction

    task automatic raise_req(instr_t word);
        instr     = word;
        in_req    = 1'b1;
        req_cycle = cycle_count;
    endtask

    task automatic complete_req();
        int n;
        n = 0;
        while (!in_ack) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("in_ack to rise");
        end
        in_req = 1'b0;
        n = 0;
        while (in_ack) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("in_ack to fall");
        end
    endtask

    task automatic send_instr(instr_t word);
        raise_req(word);
        complete_req();
    endtask

    task automatic recv_ctl(ctl_t exp, logic check_latency);
        int n;
        n = 0;
        while (!out_req) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("out_req to rise");
        end
        if (check_latency) check_count("latency", 2, cycle_count - req_cycle);
        check_ctl("ctl", exp, ctl);
        out_ack = 1'b1;
        n = 0;
        while (out_req) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("out_req to fall");
        end
        out_ack = 1'b0;
        @(negedge clk);
    endtask

    // out_req must still be low one cycle after in_req so that the latency is not short
    task automatic run_case(instr_t word, op_e op);
        raise_req(word);
        @(negedge clk);
        check_bit("out_req", 1'b0, out_req);
        complete_req();
        recv_ctl(expected_ctl(op), 1'b1);
    endtask

    task automatic run_imm(logic [2:0] f3, op_e op);
        run_case(encode(OPC_IMM, 1'b1, f3, 0, '0), op);
    endtask

    task automatic run_reg(logic [2:0] f3, logic [6:0] f7, op_e op);
        run_case(encode(OPC_REG, 1'b1, f3, 7, f7), op);
    endtask

    task automatic test_reset();
        check_bit("in_ack", 1'b0, in_ack);
        check_bit("out_req", 1'b0, out_req);
        check_ctl("ctl", '0, ctl);
    endtask

    task automatic test_alu_groups();
        run_imm(F3_ADD, ADDI);
        run_imm(F3_SLT, SLTI);
        run_imm(F3_SLTU, SLTIU);
        run_imm(F3_XOR, XORI);
        run_imm(F3_OR, ORI);
        run_imm(F3_AND, ANDI);
        run_imm(F3_SLL, SLLI);
        run_case(encode(OPC_IMM, 1'b1, F3_SR, 6, {1'b0, F6_BASE}), SRLI);
        run_case(encode(OPC_IMM, 1'b1, F3_SR, 6, {1'b0, F6_ALT}), SRAI);
        run_reg(F3_ADD, F7_BASE, ADD);
        run_reg(F3_ADD, F7_ALT, SUB);
        run_reg(F3_SLL, F7_BASE, SLL);
        run_reg(F3_SLT, F7_BASE, SLT);
        run_reg(F3_SLTU, F7_BASE, SLTU);
        run_reg(F3_XOR, F7_BASE, XOR);
        run_reg(F3_SR, F7_BASE, SRL);
        run_reg(F3_SR, F7_ALT, SRA);
        run_reg(F3_OR, F7_BASE, OR);
        run_reg(F3_AND, F7_BASE, AND);
    endtask

    task automatic test_mem_groups();
        run_case(encode(OPC_LOAD, 1'b1, F3_LB, 0, '0), LB);
        run_case(encode(OPC_LOAD, 1'b1, F3_LH, 0, '0), LH);
        run_case(encode(OPC_LOAD, 1'b1, F3_LW, 0, '0), LW);
        run_case(encode(OPC_LOAD, 1'b1, F3_LD, 0, '0), LD);
        run_case(encode(OPC_LOAD, 1'b1, F3_LBU, 0, '0), LBU);
        run_case(encode(OPC_LOAD, 1'b1, F3_LHU, 0, '0), LHU);
        run_case(encode(OPC_LOAD, 1'b1, F3_LWU, 0, '0), LWU);
        run_case(encode(OPC_STORE, 1'b1, F3_SB, 0, '0), SB);
        run_case(encode(OPC_STORE, 1'b1, F3_SH, 0, '0), SH);
        run_case(encode(OPC_STORE, 1'b1, F3_SW, 0, '0), SW);
        run_case(encode(OPC_STORE, 1'b1, F3_SD, 0, '0), SD);
    endtask

    task automatic test_flow_groups();
        run_case(encode(OPC_LUI, 1'b0, '0, 0, '0), LUI);
        run_case(encode(OPC_AUIPC, 1'b0, '0, 0, '0), AUIPC);
        run_case(encode(OPC_JAL, 1'b0, '0, 0, '0), JAL);
        run_case(encode(OPC_JALR, 1'b1, F3_JALR, 0, '0), JALR);
        run_case(encode(OPC_BRANCH, 1'b1, F3_BEQ, 0, '0), BEQ);
        run_case(encode(OPC_BRANCH, 1'b1, F3_BNE, 0, '0), BNE);
        run_case(encode(OPC_BRANCH, 1'b1, F3_BLT, 0, '0), BLT);
        run_case(encode(OPC_BRANCH, 1'b1, F3_BGE, 0, '0), BGE);
        run_case(encode(OPC_BRANCH, 1'b1, F3_BLTU, 0, '0), BLTU);
        run_case(encode(OPC_BRANCH, 1'b1, F3_BGEU, 0, '0), BGEU);
    endtask

    // word-sized groups are outside the decoded set
    task automatic test_illegal();
        run_case(encode(7'b0111011, 1'b1, F3_ADD, 7, F7_BASE), OP_UNKNOWN);
        run_case(encode(7'b0011011, 1'b1, F3_ADD, 0, '0), OP_UNKNOWN);
        run_reg(F3_XOR, F7_ALT, OP_UNKNOWN);
        run_case(encode(OPC_JALR, 1'b1, 3'b001, 0, '0), OP_UNKNOWN);
        run_case(encode(OPC_IMM, 1'b1, F3_SR, 6, 7'b0000001), OP_UNKNOWN);
        run_case(encode(OPC_LOAD, 1'b1, 3'b111, 0, '0), OP_UNKNOWN);
    endtask

    task automatic test_backpressure();
        instr_t w1;
        instr_t w2;
        instr_t w3;
        w1 = encode(OPC_REG, 1'b1, F3_ADD, 7, F7_ALT);
        w2 = encode(OPC_LOAD, 1'b1, F3_LD, 0, '0);
        w3 = encode(OPC_BRANCH, 1'b1, F3_BGEU, 0, '0);
        send_instr(w1);
        send_instr(w2);
        raise_req(w3);
        // one bundle waits at the output and one word in the capture register
        repeat (6) begin
            @(negedge clk);
            check_bit("in_ack", 1'b0, in_ack);
            check_bit("out_req", 1'b1, out_req);
            check_ctl("ctl", expected_ctl(SUB), ctl);
        end
        recv_ctl(expected_ctl(SUB), 1'b0);
        recv_ctl(expected_ctl(LD), 1'b0);
        complete_req();
        recv_ctl(expected_ctl(BGEU), 1'b0);
    endtask

    initial begin
        rst         = 1'b1;
        in_req      = 1'b0;
        instr       = '0;
        out_ack     = 1'b0;
        cycle_count = 0;
        req_cycle   = 0;
        lfsr        = 16'd69;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_reset();
        test_alu_groups();
        test_mem_groups();
        test_flow_groups();
        test_illegal();
        test_backpressure();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: verilog/alu_op_decode.sv
`timescale 1ns/1ps

module alu_op_decode
    import decoder_pkg::*;
(
    input  instr_t     instr,
    output group_ctl_t result
);
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [5:0] f6;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign f7     = instr[31:25];
    assign f6     = instr[31:26];

    always_comb begin
        result = '0;
        unique case (opcode)
            OPC_IMM: begin
                unique case (f3)
                    F3_ADD:  result = group_hit(ADDI, ALU_ADD, 1'b1, 1'b0, 1'b0);
                    F3_SLT:  result = group_hit(SLTI, ALU_SLT_S, 1'b1, 1'b0, 1'b0);
                    F3_SLTU: result = group_hit(SLTIU, ALU_SLT_U, 1'b1, 1'b0, 1'b0);
                    F3_XOR:  result = group_hit(XORI, ALU_XOR, 1'b1, 1'b0, 1'b0);
                    F3_OR:   result = group_hit(ORI, ALU_OR, 1'b1, 1'b0, 1'b0);
                    F3_AND:  result = group_hit(ANDI, ALU_AND, 1'b1, 1'b0, 1'b0);
                    F3_SLL:  result = group_hit(SLLI, ALU_SLL, 1'b1, 1'b0, 1'b0);
                    F3_SR: begin
                        // shamt[5] sits in bit 25, so funct6 picks logical or arithmetic
                        unique case (f6)
                            F6_BASE: result = group_hit(SRLI, ALU_SRL, 1'b1, 1'b0, 1'b0);
                            F6_ALT:  result = group_hit(SRAI, ALU_SRA, 1'b1, 1'b0, 1'b0);
                            default: result = '0;
                        endcase
                    end
                endcase
            end
            OPC_REG: begin
                if (f7 == F7_BASE) begin
                    unique case (f3)
                        F3_ADD:  result = group_hit(ADD, ALU_ADD, 1'b1, 1'b0, 1'b0);
                        F3_SLL:  result = group_hit(SLL, ALU_SLL, 1'b1, 1'b0, 1'b0);
                        F3_SLT:  result = group_hit(SLT, ALU_SLT_S, 1'b1, 1'b0, 1'b0);
                        F3_SLTU: result = group_hit(SLTU, ALU_SLT_U, 1'b1, 1'b0, 1'b0);
                        F3_XOR:  result = group_hit(XOR, ALU_XOR, 1'b1, 1'b0, 1'b0);
                        F3_SR:   result = group_hit(SRL, ALU_SRL, 1'b1, 1'b0, 1'b0);
                        F3_OR:   result = group_hit(OR, ALU_OR, 1'b1, 1'b0, 1'b0);
                        F3_AND:  result = group_hit(AND, ALU_AND, 1'b1, 1'b0, 1'b0);
                    endcase
                end else if (f7 == F7_ALT) begin
                    // only sub and sra have an alternate form
                    unique case (f3)
                        F3_ADD:  result = group_hit(SUB, ALU_SUB, 1'b1, 1'b0, 1'b0);
                        F3_SR:   result = group_hit(SRA, ALU_SRA, 1'b1, 1'b0, 1'b0);
                        default: result = '0;
                    endcase
                end
            end
            default: result = '0;
        endcase
    end

endmodule

// File: verilog/ctl_issue.sv
`timescale 1ns/1ps

module ctl_issue
    import decoder_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       held_valid,
    input  group_ctl_t alu_result,
    input  group_ctl_t mem_result,
    input  group_ctl_t flow_result,
    output logic       take,
    output logic       out_req,
    input  logic       out_ack,
    output ctl_t       ctl
);
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_LOW
    } issue_state_e;

    issue_state_e state;
    ctl_t         merged;

    // the groups are disjoint, so a miss everywhere leaves op at OP_UNKNOWN
    always_comb begin
        if (alu_result.hit) begin
            merged = alu_result.ctl;
        end else if (mem_result.hit) begin
            merged = mem_result.ctl;
        end else if (flow_result.hit) begin
            merged = flow_result.ctl;
        end else begin
            merged = '0;
        end
    end

    assign take    = held_valid && (state == IDLE);
    assign out_req = (state == REQ);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            ctl   <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (take) begin
                        ctl   <= merged;
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (out_ack) begin
                        state <= WAIT_LOW;
                    end
                end
                WAIT_LOW: begin
                    if (!out_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/decoder_pkg.sv
package decoder_pkg;

    typedef logic [31:0] instr_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_IMM    = 7'b0010011,
        OPC_REG    = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } major_op_e;

    // funct3 of the arithmetic groups, shared by OP-IMM and OP
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_LB   = 3'b000;
    localparam logic [2:0] F3_LH   = 3'b001;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LD   = 3'b011;
    localparam logic [2:0] F3_LBU  = 3'b100;
    localparam logic [2:0] F3_LHU  = 3'b101;
    localparam logic [2:0] F3_LWU  = 3'b110;

    localparam logic [2:0] F3_SB   = 3'b000;
    localparam logic [2:0] F3_SH   = 3'b001;
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [2:0] F3_SD   = 3'b011;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // rv64 shift immediates carry a six-bit shamt, so only funct6 is left
    localparam logic [5:0] F6_BASE = 6'b000000;
    localparam logic [5:0] F6_ALT  = 6'b010000;

    typedef enum logic [5:0] {
        OP_UNKNOWN = 6'd0,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD,
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU
    } op_e;

    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT_S, ALU_SLT_U, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_DIRECT
    } alu_func_e;

    typedef struct packed {
        op_e       op;
        alu_func_e alu_func;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
    } ctl_t;

    typedef struct packed {
        logic hit;
        ctl_t ctl;
    } group_ctl_t;

    // builds the result of a group decoder that recognised the word
    function automatic group_ctl_t group_hit(
        input op_e       op,
        input alu_func_e alu_func,
        input logic      reg_write,
        input logic      mem_read,
        input logic      mem_write
    );
        group_ctl_t g;
        g.hit           = 1'b1;
        g.ctl.op        = op;
        g.ctl.alu_func  = alu_func;
        g.ctl.reg_write = reg_write;
        g.ctl.mem_read  = mem_read;
        g.ctl.mem_write = mem_write;
        return g;
    endfunction

endpackage

// File: verilog/flow_op_decode.sv
`timescale 1ns/1ps

module flow_op_decode
    import decoder_pkg::*;
(
    input  instr_t     instr,
    output group_ctl_t result
);
    logic [6:0] opcode;
    logic [2:0] f3;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];

    always_comb begin
        result = '0;
        unique case (opcode)
            OPC_LUI:   result = group_hit(LUI, ALU_DIRECT, 1'b1, 1'b0, 1'b0);
            OPC_AUIPC: result = group_hit(AUIPC, ALU_ADD, 1'b1, 1'b0, 1'b0);
            OPC_JAL:   result = group_hit(JAL, ALU_ADD, 1'b1, 1'b0, 1'b0);
            OPC_JALR: begin
                if (f3 == F3_JALR) begin
                    result = group_hit(JALR, ALU_ADD, 1'b1, 1'b0, 1'b0);
                end
            end
            OPC_BRANCH: begin
                // branches compare elsewhere and write nothing
                unique case (f3)
                    F3_BEQ:  result = group_hit(BEQ, ALU_NOP, 1'b0, 1'b0, 1'b0);
                    F3_BNE:  result = group_hit(BNE, ALU_NOP, 1'b0, 1'b0, 1'b0);
                    F3_BLT:  result = group_hit(BLT, ALU_NOP, 1'b0, 1'b0, 1'b0);
                    F3_BGE:  result = group_hit(BGE, ALU_NOP, 1'b0, 1'b0, 1'b0);
                    F3_BLTU: result = group_hit(BLTU, ALU_NOP, 1'b0, 1'b0, 1'b0);
                    F3_BGEU: result = group_hit(BGEU, ALU_NOP, 1'b0, 1'b0, 1'b0);
                    default: result = '0;
                endcase
            end
            default: result = '0;
        endcase
    end

endmodule

// File: verilog/instr_capture.sv
`timescale 1ns/1ps

module instr_capture
    import decoder_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   in_req,
    output logic   in_ack,
    input  instr_t instr,
    output instr_t held_instr,
    output logic   held_valid,
    input  logic   take
);
    // ACKED keeps in_ack high until in_req drops, even if the word is already taken
    // HELD means the handshake is done but the word still waits for take
    typedef enum logic [1:0] {
        IDLE,
        ACKED,
        HELD
    } cap_state_e;

    cap_state_e state;
    logic       capture;

    assign capture = (state == IDLE) && in_req && !held_valid;
    assign in_ack  = (state == ACKED);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            held_valid <= 1'b0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (capture) begin
                        state <= ACKED;
                    end
                end
                ACKED: begin
                    if (!in_req) begin
                        state <= (held_valid && !take) ? HELD : IDLE;
                    end
                end
                HELD: begin
                    if (take) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase

            if (capture) begin
                held_valid <= 1'b1;
            end else if (take) begin
                held_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held_instr <= instr;
        end
    end

endmodule

// File: verilog/mem_op_decode.sv
`timescale 1ns/1ps

module mem_op_decode
    import decoder_pkg::*;
(
    input  instr_t     instr,
    output group_ctl_t result
);
    logic [6:0] opcode;
    logic [2:0] f3;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];

    always_comb begin
        result = '0;
        unique case (opcode)
            OPC_LOAD: begin
                unique case (f3)
                    F3_LB:   result = group_hit(LB, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    F3_LH:   result = group_hit(LH, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    F3_LW:   result = group_hit(LW, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    F3_LD:   result = group_hit(LD, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    F3_LBU:  result = group_hit(LBU, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    F3_LHU:  result = group_hit(LHU, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    F3_LWU:  result = group_hit(LWU, ALU_NOP, 1'b1, 1'b1, 1'b0);
                    default: result = '0;
                endcase
            end
            OPC_STORE: begin
                // store data passes straight through the alu
                unique case (f3)
                    F3_SB:   result = group_hit(SB, ALU_DIRECT, 1'b0, 1'b0, 1'b1);
                    F3_SH:   result = group_hit(SH, ALU_DIRECT, 1'b0, 1'b0, 1'b1);
                    F3_SW:   result = group_hit(SW, ALU_DIRECT, 1'b0, 1'b0, 1'b1);
                    F3_SD:   result = group_hit(SD, ALU_DIRECT, 1'b0, 1'b0, 1'b1);
                    default: result = '0;
                endcase
            end
            default: result = '0;
        endcase
    end

endmodule

// File: verilog/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder
    import decoder_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   in_req,
    output logic   in_ack,
    input  instr_t instr,
    output logic   out_req,
    input  logic   out_ack,
    output ctl_t   ctl
);
    instr_t     held_instr;
    logic       held_valid;
    logic       take;
    group_ctl_t alu_result;
    group_ctl_t mem_result;
    group_ctl_t flow_result;

    instr_capture u_capture (
        .clk        (clk),
        .rst        (rst),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .instr      (instr),
        .held_instr (held_instr),
        .held_valid (held_valid),
        .take       (take)
    );

    alu_op_decode u_alu (
        .instr  (held_instr),
        .result (alu_result)
    );

    mem_op_decode u_mem (
        .instr  (held_instr),
        .result (mem_result)
    );

    flow_op_decode u_flow (
        .instr  (held_instr),
        .result (flow_result)
    );

    ctl_issue u_issue (
        .clk         (clk),
        .rst         (rst),
        .held_valid  (held_valid),
        .alu_result  (alu_result),
        .mem_result  (mem_result),
        .flow_result (flow_result),
        .take        (take),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .ctl         (ctl)
    );

endmodule
